//--- source/serial_pkg.sv
`default_nettype none

package serial_pkg;

   localparam int XLEN = 32; // architectural word width.

   // a pass steps the counter by W up to XLEN-W, so 5 bits cover W=1.
   localparam int CNT_BITS = 5;

   typedef logic [CNT_BITS-1:0] cnt_t;

endpackage

`default_nettype wire

//--- source/pc_op_pkg.sv
`default_nettype none

package pc_op_pkg;

   typedef enum logic [2:0] {
      OP_SEQ    = 3'd0, // plain step to the next instruction.
      OP_JAL    = 3'd1,
      OP_JALR   = 3'd2,
      OP_BRANCH = 3'd3, // jumps only when taken is set.
      OP_AUIPC  = 3'd4,
      OP_LUI    = 3'd5,
      OP_TRAP   = 3'd6
   } pc_op_e;

   typedef struct packed {
      pc_op_e                        op;
      logic                          iscomp;    // 16-bit instruction steps by 2.
      logic                          taken;
      logic [serial_pkg::XLEN-1:0] offset;    // imm, or rs1 plus imm for jalr.
      logic [serial_pkg::XLEN-1:0] upper_imm;
      logic [serial_pkg::XLEN-1:0] trap_vec;
   } pc_cmd_t;

endpackage

`default_nettype wire

//--- source/pc_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pc_ctrl_if;

   logic jump;
   logic jal_or_jalr;
   logic utype;
   logic pc_rel;
   logic trap;
   logic iscomp;
   logic pc_en;      // one slice per pass cycle.
   logic cnt0;
   logic cnt1;
   logic cnt2;
   logic cnt12to15;
   logic cnt16to31;
   logic last;       // final slice of the pass.

   modport sequencer (
      output jump, jal_or_jalr, utype, pc_rel, trap, iscomp,
      output pc_en, cnt0, cnt1, cnt2, cnt12to15, cnt16to31, last
   );

   modport datapath (
      input jump, jal_or_jalr, utype, pc_rel, trap, iscomp,
      input pc_en, cnt0, cnt1, cnt2, cnt12to15, cnt16to31, last
   );

endinterface

`default_nettype wire

//--- source/pass_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pass_sequencer #(
   parameter int W = 1
) (
   input  wire               clk,
   input  wire               i_reset,
   input  wire               i_cmd_valid,
   output logic              o_cmd_ready,
   input  pc_op_pkg::pc_op_e i_op,
   input  wire               i_iscomp,
   input  wire               i_taken,
   input  wire               i_res_busy,
   pc_ctrl_if.sequencer      ctrl
);

   import serial_pkg::*;
   import pc_op_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_PASS,
      S_WAIT
   } state_e;

   state_e state;
   cnt_t   cnt;
   logic   accept;

   assign o_cmd_ready = (state == S_IDLE);
   assign accept      = i_cmd_valid & o_cmd_ready;

   // strobes mark the slice that holds the named bit position.
   assign ctrl.pc_en     = (state == S_PASS);
   assign ctrl.cnt0      = (cnt == cnt_t'(0));
   assign ctrl.cnt1      = (cnt == cnt_t'((1 / W) * W));
   assign ctrl.cnt2      = (cnt == cnt_t'((2 / W) * W));
   assign ctrl.cnt12to15 = (cnt[4:2] == 3'b011);
   assign ctrl.cnt16to31 = cnt[4];
   assign ctrl.last      = ctrl.pc_en & (cnt == cnt_t'(XLEN - W));

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state <= S_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            S_IDLE:  if (accept) state <= S_PASS;
            S_PASS:  if (ctrl.last) state <= S_WAIT;
            S_WAIT:  if (!i_res_busy) state <= S_IDLE; // result taken.
            default: state <= S_IDLE;
         endcase
         cnt <= ctrl.pc_en ? cnt + cnt_t'(W) : '0; // wraps to zero after last.
      end
   end

   // decode is captured once per command and held for the whole pass.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         ctrl.jump        <= 1'b0;
         ctrl.jal_or_jalr <= 1'b0;
         ctrl.utype       <= 1'b0;
         ctrl.pc_rel      <= 1'b0;
         ctrl.trap        <= 1'b0;
         ctrl.iscomp      <= 1'b0;
      end else if (accept) begin
         ctrl.jump        <= (i_op inside {OP_JAL, OP_JALR, OP_TRAP}) |
                             ((i_op == OP_BRANCH) & i_taken);
         ctrl.jal_or_jalr <= (i_op inside {OP_JAL, OP_JALR});
         ctrl.utype       <= (i_op inside {OP_AUIPC, OP_LUI});
         ctrl.pc_rel      <= (i_op inside {OP_JAL, OP_BRANCH, OP_AUIPC});
         ctrl.trap        <= (i_op == OP_TRAP);
         ctrl.iscomp      <= i_iscomp;
      end
   end

endmodule

`default_nettype wire

//--- source/operand_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module operand_serializer #(
   parameter int W = 1
) (
   input  wire                         clk,
   input  wire                         i_load,
   input  wire [serial_pkg::XLEN-1:0] i_offset,
   input  wire [serial_pkg::XLEN-1:0] i_upper_imm,
   input  wire [serial_pkg::XLEN-1:0] i_trap_vec,
   pc_ctrl_if.datapath                 ctrl,
   output logic [W-1:0]                o_imm_bits,
   output logic [W-1:0]                o_buf_bits,
   output logic [W-1:0]                o_csr_bits
);

   import serial_pkg::*;

   logic [2:0][XLEN-1:0] shreg; // offset, upper imm and trap vector from index 0 up.
   logic [2:0][XLEN-1:0] load_word;

   assign load_word = {i_trap_vec, i_upper_imm, i_offset};

   always_ff @(posedge clk) begin
      for (int i = 0; i < 3; i++) begin
         if (i_load)
            shreg[i] <= load_word[i];
         else if (ctrl.pc_en)
            shreg[i] <= shreg[i] >> W; // lsb first.
      end
   end

   assign o_buf_bits = shreg[0][W-1:0];
   assign o_imm_bits = shreg[1][W-1:0];
   assign o_csr_bits = shreg[2][W-1:0];

endmodule

`default_nettype wire

//--- source/pc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pc_ctrl #(
   parameter int                         W         = 1,
   parameter logic [serial_pkg::XLEN-1:0] RESET_PC  = '0,
   parameter int                         WITH_TRAP = 1
) (
   input  wire                          clk,
   input  wire                          i_reset,
   pc_ctrl_if.datapath                  ctrl,
   input  wire [W-1:0]                  i_imm,
   input  wire [W-1:0]                  i_buf,
   input  wire [W-1:0]                  i_csr_pc,
   output logic [W-1:0]                 o_rd,
   output logic [W-1:0]                 o_bad_pc,
   output logic [serial_pkg::XLEN-1:0] o_pc
);

   import serial_pkg::*;

   logic [W-1:0] pc;
   logic [W-1:0] plus_4;
   logic [W-1:0] pc_plus_4;
   logic         pc_plus_4_cy;
   logic         pc_plus_4_cy_r;
   logic [W-1:0] offset_a;
   logic [W-1:0] offset_b;
   logic [W-1:0] pc_plus_offset;
   logic         pc_plus_offset_cy;
   logic         pc_plus_offset_cy_r;
   logic [W-1:0] pc_plus_offset_aligned;
   logic [W-1:0] new_pc;

   assign pc = o_pc[W-1:0]; // current slice sits at the bottom.

   // step of 2 or 4 lands in the slice holding bit 1 or bit 2.
   generate
      if (W == 1) begin : g_step_w1
         assign plus_4 = ctrl.iscomp ? ctrl.cnt1 : ctrl.cnt2;
      end else begin : g_step_w4
         assign plus_4 = ctrl.cnt0 ? (ctrl.iscomp ? 4'd2 : 4'd4) : 4'd0;
      end
   endgenerate

   assign {pc_plus_4_cy, pc_plus_4} = {1'b0, pc} + {1'b0, plus_4} +
                                      {{W{1'b0}}, pc_plus_4_cy_r};

   assign offset_a = {W{ctrl.pc_rel}} & pc;
   assign offset_b = ctrl.utype ? (i_imm & {W{ctrl.cnt12to15 | ctrl.cnt16to31}}) : i_buf;

   assign {pc_plus_offset_cy, pc_plus_offset} = {1'b0, offset_a} + {1'b0, offset_b} +
                                                {{W{1'b0}}, pc_plus_offset_cy_r};

   assign pc_plus_offset_aligned = pc_plus_offset & ~W'(ctrl.cnt0); // bit 0 cleared.

   generate
      if (WITH_TRAP != 0) begin : g_trap
         logic [W-1:0] vec; // vector with bits 1:0 cleared.
         if (W == 1) begin : g_vec_w1
            assign vec = i_csr_pc & ~(ctrl.cnt0 | ctrl.cnt1);
         end else begin : g_vec_w4
            assign vec = i_csr_pc & (ctrl.cnt0 ? 4'b1100 : 4'b1111);
         end
         assign new_pc = ctrl.trap ? vec :
                         ctrl.jump ? pc_plus_offset_aligned : pc_plus_4;
      end else begin : g_no_trap
         // a trap falls through as a sequential step.
         assign new_pc = (ctrl.jump & ~ctrl.trap) ? pc_plus_offset_aligned : pc_plus_4;
      end
   endgenerate

   assign o_rd     = ({W{ctrl.utype}} & pc_plus_offset_aligned) |
                     ({W{ctrl.jal_or_jalr}} & pc_plus_4);
   assign o_bad_pc = pc_plus_offset_aligned;

   always_ff @(posedge clk) begin
      pc_plus_4_cy_r      <= ctrl.pc_en & pc_plus_4_cy;
      pc_plus_offset_cy_r <= ctrl.pc_en & pc_plus_offset_cy;
      if (i_reset)
         o_pc <= RESET_PC;
      else if (ctrl.pc_en)
         o_pc <= {new_pc, o_pc[XLEN-1:W]}; // new slice enters on top.
   end

endmodule

`default_nettype wire

//--- source/result_collector.sv
`timescale 1ns/1ps
`default_nettype none

module result_collector #(
   parameter int W = 1
) (
   input  wire                          clk,
   input  wire                          i_reset,
   pc_ctrl_if.datapath                  ctrl,
   input  wire [W-1:0]                  i_rd_bits,
   input  wire [W-1:0]                  i_target_bits,
   output logic                         o_res_valid,
   input  wire                          i_res_ready,
   output logic [serial_pkg::XLEN-1:0] o_res_rd,
   output logic [serial_pkg::XLEN-1:0] o_res_target,
   output logic                         o_busy
);

   import serial_pkg::*;

   always_ff @(posedge clk) begin
      if (ctrl.pc_en) begin
         o_res_rd     <= {i_rd_bits, o_res_rd[XLEN-1:W]};
         o_res_target <= {i_target_bits, o_res_target[XLEN-1:W]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset)
         o_res_valid <= 1'b0;
      else if (ctrl.last)
         o_res_valid <= 1'b1; // word complete after the final shift.
      else if (i_res_ready)
         o_res_valid <= 1'b0;
   end

   // busy drops in the cycle the result is taken.
   assign o_busy = o_res_valid & ~i_res_ready;

endmodule

`default_nettype wire

//--- source/pc_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit_top #(
   parameter int                         W         = 1,
   parameter logic [serial_pkg::XLEN-1:0] RESET_PC  = '0,
   parameter int                         WITH_TRAP = 1
) (
   input  wire                          clk,
   input  wire                          i_reset,
   input  wire                          i_cmd_valid,
   output logic                         o_cmd_ready,
   input  pc_op_pkg::pc_op_e            i_op,
   input  wire                          i_iscomp,
   input  wire                          i_taken,
   input  wire [serial_pkg::XLEN-1:0]  i_offset,
   input  wire [serial_pkg::XLEN-1:0]  i_upper_imm,
   input  wire [serial_pkg::XLEN-1:0]  i_trap_vec,
   output logic                         o_res_valid,
   input  wire                          i_res_ready,
   output logic [serial_pkg::XLEN-1:0] o_res_rd,
   output logic [serial_pkg::XLEN-1:0] o_res_target,
   output logic [serial_pkg::XLEN-1:0] o_pc
);

   import pc_op_pkg::*;

   pc_cmd_t      cmd;
   logic         load;
   logic         res_busy;
   logic [W-1:0] imm_bits;
   logic [W-1:0] buf_bits;
   logic [W-1:0] csr_bits;
   logic [W-1:0] rd_bits;
   logic [W-1:0] bad_pc_bits;

   pc_ctrl_if ctrl ();

   assign cmd = '{op: i_op, iscomp: i_iscomp, taken: i_taken, offset: i_offset,
                  upper_imm: i_upper_imm, trap_vec: i_trap_vec};

   assign load = i_cmd_valid & o_cmd_ready;

   pass_sequencer #(.W(W)) u_seq (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_cmd_valid (i_cmd_valid),
      .o_cmd_ready (o_cmd_ready),
      .i_op        (cmd.op),
      .i_iscomp    (cmd.iscomp),
      .i_taken     (cmd.taken),
      .i_res_busy  (res_busy),
      .ctrl        (ctrl.sequencer)
   );

   operand_serializer #(.W(W)) u_ops (
      .clk         (clk),
      .i_load      (load),
      .i_offset    (cmd.offset),
      .i_upper_imm (cmd.upper_imm),
      .i_trap_vec  (cmd.trap_vec),
      .ctrl        (ctrl.datapath),
      .o_imm_bits  (imm_bits),
      .o_buf_bits  (buf_bits),
      .o_csr_bits  (csr_bits)
   );

   pc_ctrl #(.W(W), .RESET_PC(RESET_PC), .WITH_TRAP(WITH_TRAP)) u_pc (
      .clk      (clk),
      .i_reset  (i_reset),
      .ctrl     (ctrl.datapath),
      .i_imm    (imm_bits),
      .i_buf    (buf_bits),
      .i_csr_pc (csr_bits),
      .o_rd     (rd_bits),
      .o_bad_pc (bad_pc_bits),
      .o_pc     (o_pc)
   );

   result_collector #(.W(W)) u_res (
      .clk           (clk),
      .i_reset       (i_reset),
      .ctrl          (ctrl.datapath),
      .i_rd_bits     (rd_bits),
      .i_target_bits (bad_pc_bits),
      .o_res_valid   (o_res_valid),
      .i_res_ready   (i_res_ready),
      .o_res_rd      (o_res_rd),
      .o_res_target  (o_res_target),
      .o_busy        (res_busy)
   );

endmodule

`default_nettype wire

//--- verification/pc_unit_properties.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit_properties #(
   parameter int W = 1
) (
   input wire       clk,
   input wire       i_reset,
   input wire       i_cmd_ready,
   input wire       i_pc_en,
   input wire       i_res_busy,
   input wire [5:0] i_ctrl_lines
);

   import serial_pkg::*;

   localparam int PASS_CYCLES = XLEN / W;

   int   run_len;               // consecutive pc_en cycles so far.
   logic excl_failed   = 1'b0;
   logic length_failed = 1'b0;
   logic stable_failed = 1'b0;

   always_ff @(posedge clk) begin
      if (i_reset)
         run_len <= 0;
      else
         run_len <= i_pc_en ? run_len + 1 : 0;
   end

   a_ready_excl: assert property (@(posedge clk) disable iff (i_reset)
      !(i_cmd_ready && (i_pc_en || i_res_busy)))
   else begin
      excl_failed = 1'b1;
      $error("command port ready while a pass runs or a result waits");
   end

   // run_len is sampled before the edge, so it holds the full pass length here.
   a_pass_len: assert property (@(posedge clk) disable iff (i_reset)
      $fell(i_pc_en) |-> (run_len == PASS_CYCLES))
   else begin
      length_failed = 1'b1;
      $error("pc_en run length differs from one pass");
   end

   a_ctrl_stable: assert property (@(posedge clk) disable iff (i_reset)
      (i_pc_en && $past(i_pc_en)) |-> $stable(i_ctrl_lines))
   else begin
      stable_failed = 1'b1;
      $error("control lines changed during a pass");
   end

endmodule

bind pass_sequencer pc_unit_properties #(.W(W)) u_props (
   .clk          (clk),
   .i_reset      (i_reset),
   .i_cmd_ready  (o_cmd_ready),
   .i_pc_en      (ctrl.pc_en),
   .i_res_busy   (i_res_busy),
   .i_ctrl_lines ({ctrl.jump, ctrl.jal_or_jalr, ctrl.utype,
                   ctrl.pc_rel, ctrl.trap, ctrl.iscomp})
);

`default_nettype wire

//--- verification/pc_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit_tb;

   import serial_pkg::*;
   import pc_op_pkg::*;

   parameter int W = 4;

   localparam logic [XLEN-1:0] RESET_PC    = 32'h0000_1000;
   localparam int              WITH_TRAP   = 1;
   localparam int              CLK_PERIOD  = 8;
   localparam int              NUM_ROWS    = 14;
   localparam int              PASS_CYCLES = XLEN / W;
   localparam int              WATCHDOG_NS = 2 * NUM_ROWS * (PASS_CYCLES + 8) * CLK_PERIOD;

   typedef struct packed {
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] rd;
      logic [XLEN-1:0] target;
   } expect_t;

   logic            clk;
   logic            reset;
   logic            cmd_valid;
   logic            cmd_ready;
   pc_op_e          op;
   logic            iscomp;
   logic            taken;
   logic [XLEN-1:0] offset;
   logic [XLEN-1:0] upper_imm;
   logic [XLEN-1:0] trap_vec;
   logic            res_valid;
   logic            res_ready;
   logic [XLEN-1:0] res_rd;
   logic [XLEN-1:0] res_target;
   logic [XLEN-1:0] pc;
   logic [31:0]     lfsr;
   int              edge_count = 0;

   pc_cmd_t stim [NUM_ROWS];
   expect_t expected [NUM_ROWS];

   pc_unit_top #(.W(W), .RESET_PC(RESET_PC), .WITH_TRAP(WITH_TRAP)) dut (
      .clk          (clk),
      .i_reset      (reset),
      .i_cmd_valid  (cmd_valid),
      .o_cmd_ready  (cmd_ready),
      .i_op         (op),
      .i_iscomp     (iscomp),
      .i_taken      (taken),
      .i_offset     (offset),
      .i_upper_imm  (upper_imm),
      .i_trap_vec   (trap_vec),
      .o_res_valid  (res_valid),
      .i_res_ready  (res_ready),
      .o_res_rd     (res_rd),
      .o_res_target (res_target),
      .o_pc         (pc)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) edge_count <= edge_count + 1;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped at %0t", $time);
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
      if (got !== want)
         abort_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, want));
   endtask

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic random_bits(input int n, output int value);
      value = 0;
      for (int b = 0; b < n; b++) begin
         lfsr  = lfsr_step(lfsr);
         value = (value << 1) | 32'(lfsr[0]);
      end
   endtask

   // expected next pc, rd and target for one command from the current pc.
   function automatic expect_t model_next(input pc_cmd_t c, input logic [XLEN-1:0] cur_pc);
      logic [XLEN-1:0] seq_pc;
      logic [XLEN-1:0] base;
      logic [XLEN-1:0] addend;
      logic            utype;
      logic            jump;
      expect_t         e;
      seq_pc   = cur_pc + (c.iscomp ? 32'd2 : 32'd4);
      base     = (c.op inside {OP_JAL, OP_BRANCH, OP_AUIPC}) ? cur_pc : '0;
      utype    = (c.op inside {OP_AUIPC, OP_LUI});
      addend   = utype ? (c.upper_imm & 32'hffff_f000) : c.offset;
      e.target = (base + addend) & ~32'd1;
      jump     = (c.op inside {OP_JAL, OP_JALR}) || ((c.op == OP_BRANCH) && c.taken);
      if ((c.op == OP_TRAP) && (WITH_TRAP != 0))
         e.pc = c.trap_vec & ~32'd3;
      else if (jump)
         e.pc = e.target;
      else
         e.pc = seq_pc;
      if (utype)
         e.rd = e.target;
      else if (c.op inside {OP_JAL, OP_JALR})
         e.rd = seq_pc;
      else
         e.rd = '0;
      return e;
   endfunction

   // op, iscomp, taken, offset, upper_imm, trap_vec.
   task automatic fill_table();
      stim[0]  = '{OP_SEQ,    1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000};
      stim[1]  = '{OP_SEQ,    1'b1, 1'b0, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000};
      stim[2]  = '{OP_JAL,    1'b0, 1'b0, 32'h0000_0100, 32'h0000_0000, 32'h0000_0000};
      stim[3]  = '{OP_JALR,   1'b1, 1'b0, 32'h0000_2003, 32'h0000_0000, 32'h0000_0000};
      stim[4]  = '{OP_BRANCH, 1'b0, 1'b1, 32'hffff_fff8, 32'h0000_0000, 32'h0000_0000};
      stim[5]  = '{OP_BRANCH, 1'b1, 1'b0, 32'h0000_0040, 32'h0000_0000, 32'h0000_0000};
      stim[6]  = '{OP_AUIPC,  1'b0, 1'b0, 32'h0000_0000, 32'h1234_5abc, 32'h0000_0000};
      stim[7]  = '{OP_LUI,    1'b1, 1'b0, 32'h0000_0000, 32'hdead_bfff, 32'h0000_0000};
      stim[8]  = '{OP_TRAP,   1'b0, 1'b0, 32'h0000_0055, 32'h0000_0000, 32'h8000_0107};
      stim[9]  = '{OP_JAL,    1'b1, 1'b0, 32'h0000_07ff, 32'h0000_0000, 32'h0000_0000};
      stim[10] = '{OP_AUIPC,  1'b1, 1'b0, 32'h0000_0000, 32'hffff_f000, 32'h0000_0000};
      stim[11] = '{OP_JALR,   1'b0, 1'b0, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0000};
      stim[12] = '{OP_SEQ,    1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000};
      stim[13] = '{OP_TRAP,   1'b1, 1'b0, 32'h0000_0010, 32'h0000_0000, 32'h0000_0403};
   endtask

   task automatic build_expected();
      logic [XLEN-1:0] model_pc;
      model_pc = RESET_PC;
      for (int i = 0; i < NUM_ROWS; i++) begin
         expected[i] = model_next(stim[i], model_pc);
         model_pc    = expected[i].pc;
      end
   endtask

   task automatic drive_command(input pc_cmd_t c);
      cmd_valid = 1'b1;
      op        = c.op;
      iscomp    = c.iscomp;
      taken     = c.taken;
      offset    = c.offset;
      upper_imm = c.upper_imm;
      trap_vec  = c.trap_vec;
   endtask

   always @(negedge clk) begin
      if (dut.u_seq.u_props.excl_failed || dut.u_seq.u_props.length_failed ||
          dut.u_seq.u_props.stable_failed)
         abort_run("an assertion on the pass sequencer failed");
   end

   initial begin
      #(WATCHDOG_NS);
      abort_run($sformatf("timeout: run did not complete within %0d ns", WATCHDOG_NS));
   end

   initial begin
      int hs_edge;
      int stall;
      clk       = 1'b0;
      reset     = 1'b1;
      cmd_valid = 1'b0;
      op        = OP_SEQ;
      iscomp    = 1'b0;
      taken     = 1'b0;
      offset    = '0;
      upper_imm = '0;
      trap_vec  = '0;
      res_ready = 1'b0;
      lfsr      = 32'hcda9;
      fill_table();
      build_expected();
      repeat (4) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check("o_pc", pc, RESET_PC);
      check("o_cmd_ready", 32'(cmd_ready), 32'd1);
      check("o_res_valid", 32'(res_valid), 32'd0);
      check("pc_en", 32'(dut.ctrl.pc_en), 32'd0);
      drive_command(stim[0]);
      for (int i = 0; i < NUM_ROWS; i++) begin
         while (!cmd_ready)
            @(negedge clk);
         hs_edge = edge_count; // handshake at the coming edge.
         @(negedge clk);
         // next command waits on the port until this result is taken.
         if (i + 1 < NUM_ROWS)
            drive_command(stim[i + 1]);
         else
            cmd_valid = 1'b0;
         while (!res_valid) begin
            check("o_cmd_ready", 32'(cmd_ready), 32'd0);
            @(negedge clk);
         end
         check("o_res_valid latency", 32'(edge_count - hs_edge), 32'(PASS_CYCLES + 1));
         random_bits(2, stall);
         repeat (stall) begin
            check("o_cmd_ready", 32'(cmd_ready), 32'd0);
            check("o_res_rd", res_rd, expected[i].rd);
            check("o_res_target", res_target, expected[i].target);
            @(negedge clk);
            check("o_res_valid", 32'(res_valid), 32'd1);
         end
         check("o_res_rd", res_rd, expected[i].rd);
         check("o_res_target", res_target, expected[i].target);
         check("o_pc", pc, expected[i].pc);
         check("o_cmd_ready", 32'(cmd_ready), 32'd0);
         res_ready = 1'b1;
         @(negedge clk);
         res_ready = 1'b0;
         check("o_res_valid", 32'(res_valid), 32'd0);
      end
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
source/serial_pkg.sv
source/pc_op_pkg.sv
source/pc_ctrl_if.sv
source/pass_sequencer.sv
source/operand_serializer.sv
source/pc_ctrl.sv
source/result_collector.sv
source/pc_unit_top.sv
verification/pc_unit_properties.sv
verification/pc_unit_tb.sv

//--- Makefile
# Verilator lint and simulation for the serial pc unit.

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= pc_unit_tb
RTL_TOP   ?= pc_unit_top
W         ?= 4
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+16

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP) -GW=$(W)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -GW=$(W)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -GW=$(W) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
